// File: hw/wb_bus_master.sv
// wishbone bus master, turns single host command strobes into classic bus cycles
`timescale 1ns/1ns
module wb_bus_master (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              cmd_valid_i,
    input  wb_pkg::host_cmd_t cmd_i,
    output logic              rsp_valid_o,
    output wb_pkg::host_rsp_t rsp_o,
    output logic              busy_o,
    output wb_pkg::wb_req_t   wb_req_o,
    input  wb_pkg::wb_rsp_t   wb_rsp_i
);
    import wb_pkg::*;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_BUS,
        ST_RESP
    } state_t;

    state_t           state_q;
    state_t           state_d;
    host_cmd_t        cmd_q;
    logic [WB_DW-1:0] rdat_q;

    // next state
    always_comb begin
        state_d = state_q;
        case (state_q)
            ST_IDLE: begin
                if (cmd_valid_i) begin
                    state_d = ST_BUS;
                end
            end
            ST_BUS: begin
                // hold the cycle until the slave acks
                if (wb_rsp_i.ack) begin
                    state_d = ST_RESP;
                end
            end
            default: begin
                // response strobe lasts one cycle
                state_d = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // command only valid with its strobe, so keep a copy
    always_ff @(posedge clk) begin
        if (cmd_valid_i && state_q == ST_IDLE) begin
            cmd_q <= cmd_i;
        end
    end

    // capture read data on the ack edge
    always_ff @(posedge clk) begin
        if (state_q == ST_BUS && wb_rsp_i.ack) begin
            rdat_q <= cmd_q.we ? '0 : wb_rsp_i.dat;
        end
    end

    // request fields only driven during the cycle
    always_comb begin
        wb_req_o = '0;
        if (state_q == ST_BUS) begin
            wb_req_o.we  = cmd_q.we;
            wb_req_o.cyc = 1'b1;
            wb_req_o.stb = 1'b1;
            wb_req_o.sel = cmd_q.sel;
            wb_req_o.adr = cmd_q.adr;
            wb_req_o.dat = cmd_q.wdat;
        end
    end

    assign busy_o      = (state_q != ST_IDLE);
    assign rsp_valid_o = (state_q == ST_RESP);
    assign rsp_o.rdat  = rdat_q;

    // no buffering, host must wait for the response
    a_no_cmd_when_busy: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        cmd_valid_i |-> !busy_o
    ) else $error("command strobe while master busy");

    // wishbone rule, request held until ack
    a_req_stable: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        (wb_req_o.stb && !wb_rsp_i.ack) |=> $stable(wb_req_o)
    ) else $error("request changed before ack");

endmodule

// File: hw/wb_interconnect.sv
// wishbone address decoder, routes one master to two slaves and gathers interrupts
`timescale 1ns/1ns
module wb_interconnect #(
    parameter logic [wb_pkg::SLV_SEL_MSB-wb_pkg::SLV_SEL_LSB:0] ADDR_0 = 8'h00,
    parameter logic [wb_pkg::SLV_SEL_MSB-wb_pkg::SLV_SEL_LSB:0] ADDR_1 = 8'h01
) (
    input  wb_pkg::wb_req_t m_req_i,
    output wb_pkg::wb_rsp_t m_rsp_o,
    output wb_pkg::wb_req_t s0_req_o,
    output wb_pkg::wb_req_t s1_req_o,
    input  wb_pkg::wb_rsp_t s0_rsp_i,
    input  wb_pkg::wb_rsp_t s1_rsp_i,
    output logic            int_o
);
    import wb_pkg::*;

    logic [SLV_SEL_MSB-SLV_SEL_LSB:0] slave_select;
    logic                             hit_0;
    logic                             hit_1;
    wb_req_t                          req_local;
    logic [WB_DW-1:0]                 irq_vec;

    assign slave_select = m_req_i.adr[SLV_SEL_MSB:SLV_SEL_LSB];
    assign hit_0        = (slave_select == ADDR_0);
    assign hit_1        = (slave_select == ADDR_1);

    // slaves see a local address, select byte stripped
    always_comb begin
        req_local = m_req_i;
        req_local.adr[SLV_SEL_MSB:SLV_SEL_LSB] = '0;
    end

    // unselected slave gets an idle bus
    assign s0_req_o = hit_0 ? req_local : '0;
    assign s1_req_o = hit_1 ? req_local : '0;

    // interrupt vector, bit per slave
    always_comb begin
        irq_vec    = '0;
        irq_vec[0] = s0_rsp_i.irq;
        irq_vec[1] = s1_rsp_i.irq;
    end

    assign int_o = |irq_vec;

    // response mux
    always_comb begin
        m_rsp_o.irq = int_o;
        if (hit_0) begin
            m_rsp_o.ack = s0_rsp_i.ack;
            m_rsp_o.dat = s0_rsp_i.dat;
        end else if (hit_1) begin
            m_rsp_o.ack = s1_rsp_i.ack;
            m_rsp_o.dat = s1_rsp_i.dat;
        end else begin
            // unmapped, answer at once with the vector
            // writes land nowhere
            m_rsp_o.ack = m_req_i.cyc && m_req_i.stb;
            m_rsp_o.dat = irq_vec;
        end
    end

    // catches equal ADDR_0 and ADDR_1 from the top
    always_comb begin
        a_one_slave: assert (!(s0_req_o.stb && s1_req_o.stb))
            else $error("both slaves strobed");
    end

endmodule

// File: hw/wb_pkg.sv
// shared wishbone bus, host command and address map definitions for the subsystem
package wb_pkg;

    // bus widths
    localparam int WB_AW = 32;
    localparam int WB_DW = 32;

    // top address byte picks the slave
    localparam int SLV_SEL_MSB = 31;
    localparam int SLV_SEL_LSB = 24;

    // timer register word offsets
    localparam logic [3:0] TMR_CTRL  = 4'h0;
    localparam logic [3:0] TMR_COUNT = 4'h4;
    localparam logic [3:0] TMR_CMP   = 4'h8;
    localparam logic [3:0] TMR_STAT  = 4'hC;

    // timer control bits
    localparam int TMR_EN_BIT     = 0;
    localparam int TMR_IRQ_EN_BIT = 1;

    // one classic wishbone request, 71 bits
    typedef struct packed {
        logic             we;
        logic             cyc;
        logic             stb;
        logic [3:0]       sel;
        logic [WB_AW-1:0] adr;
        logic [WB_DW-1:0] dat;
    } wb_req_t;

    // one slave response, 34 bits
    typedef struct packed {
        logic             ack;
        logic [WB_DW-1:0] dat;
        logic             irq;
    } wb_rsp_t;

    // host command, valid with its strobe only
    typedef struct packed {
        logic             we;
        logic [3:0]       sel;
        logic [WB_AW-1:0] adr;
        logic [WB_DW-1:0] wdat;
    } host_cmd_t;

    // host response, zero data for writes
    typedef struct packed {
        logic [WB_DW-1:0] rdat;
    } host_rsp_t;

endpackage

// File: hw/wb_scratch_ram.sv
// wishbone slave scratch memory with byte lane writes and registered ack
`timescale 1ns/1ns
module wb_scratch_ram #(
    parameter int RAM_WORDS = 64
) (
    input  logic            clk,
    input  logic            rst_n_i,
    input  wb_pkg::wb_req_t wb_req_i,
    output wb_pkg::wb_rsp_t wb_rsp_o
);
    import wb_pkg::*;

    localparam int IDX_W = $clog2(RAM_WORDS);

    logic [WB_DW-1:0] mem [RAM_WORDS];
    logic [IDX_W-1:0] idx;
    logic             access;
    logic             ack_q;
    logic [WB_DW-1:0] rdat_q;

    // word address, wraps at RAM_WORDS
    assign idx = wb_req_i.adr[2 +: IDX_W];

    // only the first cycle of a strobe counts
    assign access = wb_req_i.cyc && wb_req_i.stb && !ack_q;

    // ack one cycle after strobe, dropped the cycle after
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    always_ff @(posedge clk) begin
        if (access && wb_req_i.we) begin
            // each lane gated by its sel bit
            for (int b = 0; b < 4; b++) begin
                if (wb_req_i.sel[b]) begin
                    mem[idx][8*b +: 8] <= wb_req_i.dat[8*b +: 8];
                end
            end
        end
        if (access && !wb_req_i.we) begin
            rdat_q <= mem[idx];
        end
    end

    assign wb_rsp_o.ack = ack_q;
    assign wb_rsp_o.dat = rdat_q;
    // no interrupt source here
    assign wb_rsp_o.irq = 1'b0;

endmodule

// File: hw/wb_subsys_top.sv
// wishbone subsystem top, host port master with scratch ram and timer slaves
`timescale 1ns/1ns
module wb_subsys_top #(
    parameter logic [wb_pkg::SLV_SEL_MSB-wb_pkg::SLV_SEL_LSB:0] ADDR_0 = 8'h00,
    parameter logic [wb_pkg::SLV_SEL_MSB-wb_pkg::SLV_SEL_LSB:0] ADDR_1 = 8'h01,
    parameter int RAM_WORDS = 64,
    parameter int CNT_W     = 16
) (
    input  logic              clk,
    input  logic              rst_n_i,
    input  logic              cmd_valid_i,
    input  wb_pkg::host_cmd_t cmd_i,
    output logic              rsp_valid_o,
    output wb_pkg::host_rsp_t rsp_o,
    output logic              busy_o,
    output logic              int_o
);
    import wb_pkg::*;

    // master side
    wb_req_t m_req;
    wb_rsp_t m_rsp;
    // slave side
    wb_req_t s0_req;
    wb_rsp_t s0_rsp;
    wb_req_t s1_req;
    wb_rsp_t s1_rsp;

    wb_bus_master u_master (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .cmd_valid_i (cmd_valid_i),
        .cmd_i       (cmd_i),
        .rsp_valid_o (rsp_valid_o),
        .rsp_o       (rsp_o),
        .busy_o      (busy_o),
        .wb_req_o    (m_req),
        .wb_rsp_i    (m_rsp)
    );

    wb_interconnect #(
        .ADDR_0 (ADDR_0),
        .ADDR_1 (ADDR_1)
    ) u_icon (
        .m_req_i  (m_req),
        .m_rsp_o  (m_rsp),
        .s0_req_o (s0_req),
        .s1_req_o (s1_req),
        .s0_rsp_i (s0_rsp),
        .s1_rsp_i (s1_rsp),
        .int_o    (int_o)
    );

    // slave 0
    wb_scratch_ram #(
        .RAM_WORDS (RAM_WORDS)
    ) u_ram (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .wb_req_i (s0_req),
        .wb_rsp_o (s0_rsp)
    );

    // slave 1
    wb_timer #(
        .CNT_W (CNT_W)
    ) u_timer (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .wb_req_i (s1_req),
        .wb_rsp_o (s1_rsp)
    );

endmodule

// File: hw/wb_timer.sv
// wishbone slave compare timer, free counter with match flag and interrupt
`timescale 1ns/1ns
module wb_timer #(
    parameter int CNT_W = 16
) (
    input  logic            clk,
    input  logic            rst_n_i,
    input  wb_pkg::wb_req_t wb_req_i,
    output wb_pkg::wb_rsp_t wb_rsp_o
);
    import wb_pkg::*;

    logic             access;
    logic             ack_q;
    logic [WB_DW-1:0] rdat_q;
    logic             en_q;
    logic             irq_en_q;
    logic [CNT_W-1:0] cmp_q;
    logic [CNT_W-1:0] count_q;
    logic             pending_q;
    logic             wr_ctrl;
    logic             wr_cmp;
    logic             wr_stat;
    logic             match;

    assign access = wb_req_i.cyc && wb_req_i.stb && !ack_q;

    // register decode, low nibble only
    assign wr_ctrl = access && wb_req_i.we && (wb_req_i.adr[3:0] == TMR_CTRL);
    assign wr_cmp  = access && wb_req_i.we && (wb_req_i.adr[3:0] == TMR_CMP);
    assign wr_stat = access && wb_req_i.we && (wb_req_i.adr[3:0] == TMR_STAT);

    assign match = en_q && (count_q == cmp_q);

    // single cycle ack
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= access;
        end
    end

    // control and compare
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            en_q     <= 1'b0;
            irq_en_q <= 1'b0;
            cmp_q    <= '0;
        end else begin
            if (wr_ctrl) begin
                en_q     <= wb_req_i.dat[TMR_EN_BIT];
                irq_en_q <= wb_req_i.dat[TMR_IRQ_EN_BIT];
            end
            if (wr_cmp) begin
                cmp_q <= wb_req_i.dat[CNT_W-1:0];
            end
        end
    end

    // counter, pending flag
    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            count_q   <= '0;
            pending_q <= 1'b0;
        end else begin
            // control or new compare restarts the period
            if (wr_ctrl || wr_cmp) begin
                count_q <= '0;
            end else if (match) begin
                count_q <= '0;
            end else if (en_q) begin
                count_q <= count_q + 1'b1;
            end
            // a fresh match wins over the clear
            if (match) begin
                pending_q <= 1'b1;
            end else if (wr_stat && wb_req_i.dat[0]) begin
                pending_q <= 1'b0;
            end
        end
    end

    // read mux, registered with ack
    always_ff @(posedge clk) begin
        if (access && !wb_req_i.we) begin
            case (wb_req_i.adr[3:0])
                TMR_CTRL: begin
                    rdat_q                 <= '0;
                    rdat_q[TMR_EN_BIT]     <= en_q;
                    rdat_q[TMR_IRQ_EN_BIT] <= irq_en_q;
                end
                TMR_COUNT: rdat_q <= WB_DW'(count_q);
                TMR_CMP:   rdat_q <= WB_DW'(cmp_q);
                TMR_STAT:  rdat_q <= WB_DW'(pending_q);
                default:   rdat_q <= '0;
            endcase
        end
    end

    assign wb_rsp_o.ack = ack_q;
    assign wb_rsp_o.dat = rdat_q;
    assign wb_rsp_o.irq = pending_q && irq_en_q;

    // count wraps at compare, never runs past it
    a_count_le_cmp: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        en_q |-> (count_q <= cmp_q)
    ) else $error("timer count above compare");

endmodule

// File: list.f
hw/wb_pkg.sv
hw/wb_bus_master.sv
hw/wb_interconnect.sv
hw/wb_scratch_ram.sv
hw/wb_timer.sv
hw/wb_subsys_top.sv
tb/tb_wb_subsys.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the wishbone subsystem testbench with verilator
set -e

cd "$(dirname "$0")"
LOG=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module tb_wb_subsys \
    -f list.f \
    -o sim_tb

status=0
./obj_dir/sim_tb > "$LOG" 2>&1 || status=$?
cat "$LOG"

if grep -q "TB FAILED" "$LOG" || [ "$status" -ne 0 ]; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"

// File: tb/tb_wb_subsys.sv
// testbench for the wishbone subsystem, random ram traffic, unmapped accesses and timer irq
`timescale 1ns/1ns
module tb_wb_subsys;
    import wb_pkg::*;

    localparam logic [7:0] ADDR_0    = 8'h00;
    localparam logic [7:0] ADDR_1    = 8'h01;
    localparam int         RAM_WORDS = 64;
    localparam int         CNT_W     = 16;
    localparam int         N_RAND    = 16;
    localparam int         N_UNW     = 4;
    localparam int         CMP_MAX   = 17;
    // fill, random writes and reads, unmapped pass, timer pass
    localparam int N_CMDS      = RAM_WORDS + 2 * N_RAND + 1 + 2 * N_UNW + 8;
    localparam int CYCLE_LIMIT = 20 * N_CMDS + CMP_MAX + 5;

    logic        clk;
    logic        rst_n;
    logic        cmd_valid;
    host_cmd_t   cmd;
    logic        rsp_valid;
    host_rsp_t   rsp;
    logic        busy;
    logic        int_out;

    // expected values, set with each command
    logic        started;
    logic [31:0] exp_rdat;
    int          exp_lat;
    int          lat_cnt;
    logic        irq_watch;
    int          irq_cnt;
    int          irq_limit;
    int          int_low_chk;
    int          cycles = 0;
    logic [31:0] lfsr_q;
    logic [31:0] ram_model [RAM_WORDS];
    string       test_name;

    wb_subsys_top #(
        .ADDR_0    (ADDR_0),
        .ADDR_1    (ADDR_1),
        .RAM_WORDS (RAM_WORDS),
        .CNT_W     (CNT_W)
    ) dut (
        .clk         (clk),
        .rst_n_i     (rst_n),
        .cmd_valid_i (cmd_valid),
        .cmd_i       (cmd),
        .rsp_valid_o (rsp_valid),
        .rsp_o       (rsp),
        .busy_o      (busy),
        .int_o       (int_out)
    );

    initial begin
        clk = 1'b0;
    end

    always #4 clk = ~clk;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic report_mismatch(input logic [31:0] exp_val, input logic [31:0] act_val);
        abort_run($sformatf("[ERROR] %s: expected 0x%08h actual 0x%08h",
                            test_name, exp_val, act_val));
    endtask

    // galois lfsr, one step per bit taken
    function automatic logic lfsr_next_bit();
        logic out_bit;
        out_bit = lfsr_q[0];
        lfsr_q  = lfsr_q >> 1;
        if (out_bit) begin
            lfsr_q = lfsr_q ^ 32'hD000_0001;
        end
        return out_bit;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v = {v[30:0], lfsr_next_bit()};
        end
        return v;
    endfunction

    function automatic logic [31:0] ram_addr(input int word);
        return {ADDR_0, 24'(word * 4)};
    endfunction

    function automatic logic [31:0] tmr_addr(input logic [3:0] offset);
        return {ADDR_1, 20'h0, offset};
    endfunction

    // byte lane merge as the bus defines it
    function automatic logic [31:0] merge_lanes(input logic [31:0] old_word,
                                                input logic [31:0] new_word,
                                                input logic [3:0]  sel);
        logic [31:0] w;
        w = old_word;
        for (int b = 0; b < 4; b++) begin
            if (sel[b]) begin
                w[8*b +: 8] = new_word[8*b +: 8];
            end
        end
        return w;
    endfunction

    // one command strobe, back at a rising edge after the response
    task automatic issue(input logic we_in, input logic [3:0] sel_in, input logic [31:0] adr_in,
                         input logic [31:0] wdat_in, input logic [31:0] rdat_exp);
        host_cmd_t  c;
        logic [7:0] slv;
        slv    = adr_in[31:24];
        c.we   = we_in;
        c.sel  = sel_in;
        c.adr  = adr_in;
        c.wdat = wdat_in;
        cmd_valid <= 1'b1;
        cmd       <= c;
        started   <= 1'b1;
        exp_rdat  <= we_in ? 32'h0 : rdat_exp;
        // mapped slaves add the registered slave ack
        exp_lat   <= (slv == ADDR_0 || slv == ADDR_1) ? 3 : 2;
        @(posedge clk);
        cmd_valid <= 1'b0;
        cmd       <= '0;
        // sample the strobe away from the active edge
        @(negedge clk);
        while (!rsp_valid) begin
            @(negedge clk);
        end
        @(posedge clk);
    endtask

    // cycles since the last command strobe
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lat_cnt <= 0;
        end else if (cmd_valid) begin
            lat_cnt <= 1;
        end else begin
            lat_cnt <= lat_cnt + 1;
        end
    end

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            irq_cnt <= 0;
        end else if (irq_watch) begin
            irq_cnt <= irq_cnt + 1;
        end else begin
            irq_cnt <= 0;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            abort_run($sformatf("timeout, tests not finished after %0d cycles", cycles));
        end
    end

    // outputs quiet until the first command
    a_idle_after_reset: assert property (
        @(posedge clk) disable iff (!rst_n)
        !started |-> (!rsp_valid && !busy && !int_out)
    ) else report_mismatch(32'h0, {29'h0, $sampled(rsp_valid), $sampled(busy), $sampled(int_out)});

    a_latency: assert property (
        @(posedge clk) disable iff (!rst_n)
        rsp_valid |-> (lat_cnt == exp_lat)
    ) else report_mismatch(exp_lat, $sampled(lat_cnt));

    // busy from the cycle after the strobe through the response cycle
    a_busy_window: assert property (
        @(posedge clk) disable iff (!rst_n)
        (started && !cmd_valid) |-> (busy == (lat_cnt <= exp_lat))
    ) else report_mismatch(32'($sampled(lat_cnt) <= $sampled(exp_lat)), 32'($sampled(busy)));

    a_rdat: assert property (
        @(posedge clk) disable iff (!rst_n)
        rsp_valid |-> (rsp.rdat == exp_rdat)
    ) else report_mismatch(exp_rdat, $sampled(rsp.rdat));

    a_irq_in_time: assert property (
        @(posedge clk) disable iff (!rst_n)
        (irq_watch && !int_out) |-> (irq_cnt < irq_limit)
    ) else abort_run($sformatf("int_o did not rise within %0d cycles of the timer enable",
                               irq_limit));

    a_int_cleared: assert property (
        @(posedge clk) disable iff (!rst_n)
        (int_low_chk != 0) |-> !int_out
    ) else report_mismatch(32'h0, 32'($sampled(int_out)));

    initial begin
        logic [31:0] r;
        logic [5:0]  idx;
        logic [5:0]  idx_list [N_RAND];
        logic [3:0]  sel;
        logic [31:0] dat;
        logic [31:0] fill;
        logic [7:0]  unmapped;
        logic [31:0] cmp_val;
        logic [31:0] ctrl_val;
        rst_n       <= 1'b0;
        cmd_valid   <= 1'b0;
        cmd         <= '0;
        started     <= 1'b0;
        exp_rdat    <= '0;
        exp_lat     <= 0;
        irq_watch   <= 1'b0;
        irq_limit   <= 0;
        int_low_chk <= 0;
        lfsr_q      = 32'd6;
        test_name   = "reset";
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
        // idle window
        repeat (3) @(posedge clk);

        // known contents, pattern from the full word index
        test_name = "ram fill";
        for (int i = 0; i < RAM_WORDS; i++) begin
            fill         = {2{8'(i) ^ 8'h3C, ~8'(i)}};
            ram_model[i] = fill;
            issue(1'b1, 4'hF, ram_addr(i), fill, 32'h0);
        end

        test_name = "ram random write";
        for (int n = 0; n < N_RAND; n++) begin
            r   = rand_bits(6);
            idx = r[5:0];
            r   = rand_bits(4);
            sel = r[3:0];
            dat = rand_bits(32);
            idx_list[n]    = idx;
            ram_model[idx] = merge_lanes(ram_model[idx], dat, sel);
            issue(1'b1, sel, ram_addr(int'(idx)), dat, 32'h0);
        end
        test_name = "ram random read";
        for (int n = 0; n < N_RAND; n++) begin
            issue(1'b0, 4'hF, ram_addr(int'(idx_list[n])), 32'h0, ram_model[idx_list[n]]);
        end

        // any select byte above slave 1
        test_name = "unmapped idle";
        r        = rand_bits(7);
        unmapped = 8'h02 + {1'b0, r[6:0]};
        issue(1'b0, 4'hF, {unmapped, 24'h0}, 32'h0, 32'h0);
        // same low address bits as ram words, must not land there
        test_name = "unmapped write";
        for (int n = 0; n < N_UNW; n++) begin
            dat = rand_bits(32);
            issue(1'b1, 4'hF, {unmapped, 24'(int'(idx_list[n]) * 4)}, dat, 32'h0);
        end
        test_name = "unmapped reread";
        for (int n = 0; n < N_UNW; n++) begin
            issue(1'b0, 4'hF, ram_addr(int'(idx_list[n])), 32'h0, ram_model[idx_list[n]]);
        end

        test_name = "timer setup";
        r       = rand_bits(4);
        cmp_val = 32'd2 + {28'h0, r[3:0]};
        issue(1'b1, 4'hF, tmr_addr(TMR_CMP), cmp_val, 32'h0);
        ctrl_val                 = '0;
        ctrl_val[TMR_EN_BIT]     = 1'b1;
        ctrl_val[TMR_IRQ_EN_BIT] = 1'b1;
        issue(1'b1, 4'hF, tmr_addr(TMR_CTRL), ctrl_val, 32'h0);

        test_name = "timer irq";
        irq_limit <= int'(cmp_val) + 4;
        irq_watch <= 1'b1;
        @(negedge clk);
        while (!int_out) begin
            @(negedge clk);
        end
        @(posedge clk);
        irq_watch <= 1'b0;
        issue(1'b0, 4'hF, tmr_addr(TMR_STAT), 32'h0, 32'h1);
        test_name = "vector pending";
        issue(1'b0, 4'hF, {unmapped, 24'h0}, 32'h0, 32'h2);

        // stop the counter first so no new match sets pending again
        test_name = "timer clear";
        ctrl_val                 = '0;
        ctrl_val[TMR_IRQ_EN_BIT] = 1'b1;
        issue(1'b1, 4'hF, tmr_addr(TMR_CTRL), ctrl_val, 32'h0);
        issue(1'b1, 4'hF, tmr_addr(TMR_STAT), 32'h1, 32'h0);
        int_low_chk <= 1;
        test_name = "vector cleared";
        issue(1'b0, 4'hF, {unmapped, 24'h0}, 32'h0, 32'h0);
        issue(1'b0, 4'hF, tmr_addr(TMR_STAT), 32'h0, 32'h0);

        repeat (4) @(posedge clk);
        $display("TB PASSED");
        $finish;
    end

endmodule
